//--- Makefile
TOP = stageOneTb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation ended without a verdict"; exit 1)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- source/controlDecode.sv
`timescale 1ns/100ps

module controlDecode (
	input stageOnePkg::seqState_t state,
	input stageOnePkg::opcode_t opcode,
	input stageOnePkg::addrMode_t addrMode,
	input logic [stageOnePkg::SHIFT_AMOUNT_WIDTH-1:0] shiftData,
	output stageOnePkg::aluOp_t aluOp,
	output logic accWrite,
	output logic memRead,
	output logic memWrite,
	output logic shiftEnable,
	output logic shiftLeft,
	output logic shiftFill,
	output logic [stageOnePkg::SHIFT_AMOUNT_WIDTH-1:0] shiftAmount,
	output logic inputTaken,
	output logic outputValid
);
	import stageOnePkg::*;

	shiftKind_t shiftKind;
	aluOp_t execOp;

	assign shiftKind = shiftKind_t'(addrMode);

	// ALU selection for the execute step
	always_comb begin
		case (opcode)
			OP_ADD: execOp = ALU_ADD;
			OP_SUB: execOp = ALU_SUB;
			OP_OR: execOp = ALU_OR;
			OP_AND: execOp = ALU_AND;
			default: execOp = ALU_PASS;  // LOAD
		endcase
	end

	always_comb begin
		aluOp = ALU_PASS;
		accWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		shiftEnable = 1'b0;
		shiftLeft = 1'b0;
		shiftFill = 1'b0;
		shiftAmount = '0;
		inputTaken = 1'b0;
		outputValid = 1'b0;
		case (state)
			S_PTR_READ, S_MEM_READ: memRead = 1'b1;
			S_MEM_WRITE: memWrite = 1'b1;
			S_EXECUTE: begin
				aluOp = execOp;
				accWrite = 1'b1;
			end
			S_SHIFT: begin
				shiftEnable = 1'b1;
				shiftLeft = (shiftKind == SHIFT_LEFT_ZERO) || (shiftKind == SHIFT_LEFT_ONE);
				shiftFill = (shiftKind == SHIFT_LEFT_ONE) || (shiftKind == SHIFT_RIGHT_ONE);
				shiftAmount = shiftData;
			end
			S_IN_TAKE: begin
				accWrite = 1'b1;  // Device byte straight into the accumulator
				inputTaken = 1'b1;
			end
			S_OUT_DRIVE: outputValid = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
	input logic clk,
	input logic reset,
	input logic instrLoad,
	input logic [stageOnePkg::INSTR_WIDTH-1:0] instr,
	input logic [stageOnePkg::DATA_WIDTH-1:0] irData,
	output stageOnePkg::opcode_t opcode,
	output stageOnePkg::addrMode_t addrMode,
	output logic [stageOnePkg::SHIFT_AMOUNT_WIDTH-1:0] shiftData
);
	import stageOnePkg::*;

	logic [4:0] rawOp;
	logic [2:0] rawMode;
	opcode_t decOpcode;
	addrMode_t decMode;
	opcode_t opcodeReg;
	addrMode_t modeReg;
	logic [SHIFT_AMOUNT_WIDTH-1:0] shiftReg;

	assign rawOp = instr[7:3];
	assign rawMode = instr[2:0];

	// Anything the sequencer cannot run becomes NOP
	always_comb begin
		decOpcode = OP_NOP;
		decMode = MODE_DIRECT;
		case (rawOp)
			OP_ADD, OP_SUB, OP_OR, OP_AND, OP_LOAD: begin
				if (rawMode <= MODE_IMMEDIATE) begin
					decOpcode = opcode_t'(rawOp);
					decMode = addrMode_t'(rawMode);
				end
			end
			OP_STOR: begin
				if (rawMode <= MODE_INDIRECT) begin
					decOpcode = OP_STOR;
					decMode = addrMode_t'(rawMode);
				end
			end
			OP_SHFT: begin
				if (rawMode <= SHIFT_RIGHT_ONE) begin
					decOpcode = OP_SHFT;
					decMode = addrMode_t'(rawMode);  // Carries the shift kind
				end
			end
			OP_INPUT, OP_OUTPUT: decOpcode = opcode_t'(rawOp);
			default: decOpcode = OP_NOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			opcodeReg <= OP_NOP;
			modeReg <= MODE_DIRECT;
		end else if (instrLoad) begin
			opcodeReg <= decOpcode;
			modeReg <= decMode;
		end
	end

	always_ff @(posedge clk) begin
		if (instrLoad)
			shiftReg <= irData[SHIFT_AMOUNT_WIDTH-1:0];
	end

	// Bypass in the accept cycle so the first state can be chosen
	assign opcode = instrLoad ? decOpcode : opcodeReg;
	assign addrMode = instrLoad ? decMode : modeReg;
	assign shiftData = shiftReg;

endmodule

//--- source/memWaitTimer.sv
`timescale 1ns/100ps

module memWaitTimer (
	input logic clk,
	input logic reset,
	input logic memActive,
	input logic cacheHit,
	output logic memDone
);
	import stageOnePkg::*;

	logic [MISS_COUNT_WIDTH-1:0] missCount;
	logic limitHit;

	assign limitHit = (missCount == MISS_COUNT_WIDTH'(MISS_LIMIT));

	// Hit ends it at once, otherwise the eleventh miss cycle does
	assign memDone = memActive && (cacheHit || limitHit);

	always_ff @(posedge clk) begin
		if (reset) begin
			missCount <= '0;
		end else if (!memActive || memDone) begin
			missCount <= '0;  // Fresh count per access
		end else begin
			missCount <= missCount + 1'b1;
		end
	end

endmodule

//--- source/stageOneCtrl.sv
`timescale 1ns/100ps

module stageOneCtrl (
	input logic clk,
	input logic reset,
	input logic [stageOnePkg::INSTR_WIDTH-1:0] instr,
	input logic [stageOnePkg::DATA_WIDTH-1:0] irData,
	input logic instrValid,
	input logic cacheHit,
	input logic inputReady,
	input logic outputTaken,
	output logic instrAccept,
	output stageOnePkg::aluOp_t aluOp,
	output logic accWrite,
	output logic memRead,
	output logic memWrite,
	output logic shiftEnable,
	output logic shiftLeft,
	output logic shiftFill,
	output logic [stageOnePkg::SHIFT_AMOUNT_WIDTH-1:0] shiftAmount,
	output logic inputTaken,
	output logic outputValid
);
	import stageOnePkg::*;

	logic instrLoad;
	opcode_t opcode;
	addrMode_t addrMode;
	logic [SHIFT_AMOUNT_WIDTH-1:0] shiftData;
	logic memActive;
	logic memDone;
	seqState_t state;

	instrDecoder instrDecoder_i (
		.clk(clk),
		.reset(reset),
		.instrLoad(instrLoad),
		.instr(instr),
		.irData(irData),
		.opcode(opcode),
		.addrMode(addrMode),
		.shiftData(shiftData)
	);

	memWaitTimer memWaitTimer_i (
		.clk(clk),
		.reset(reset),
		.memActive(memActive),
		.cacheHit(cacheHit),
		.memDone(memDone)
	);

	stageSequencer stageSequencer_i (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.opcode(opcode),
		.addrMode(addrMode),
		.memDone(memDone),
		.inputReady(inputReady),
		.outputTaken(outputTaken),
		.instrAccept(instrAccept),
		.instrLoad(instrLoad),
		.memActive(memActive),
		.state(state)
	);

	controlDecode controlDecode_i (
		.state(state),
		.opcode(opcode),
		.addrMode(addrMode),
		.shiftData(shiftData),
		.aluOp(aluOp),
		.accWrite(accWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.shiftEnable(shiftEnable),
		.shiftLeft(shiftLeft),
		.shiftFill(shiftFill),
		.shiftAmount(shiftAmount),
		.inputTaken(inputTaken),
		.outputValid(outputValid)
	);

endmodule

//--- source/stageOnePkg.sv
package stageOnePkg;

	////////////////////////////////////////////////////////////
	// Widths and limits
	////////////////////////////////////////////////////////////
	localparam int INSTR_WIDTH = 8;
	localparam int DATA_WIDTH = 8;
	localparam int SHIFT_AMOUNT_WIDTH = 3;
	localparam int MISS_LIMIT = 10;  // Miss cycles before giving up on the cache
	localparam int MISS_COUNT_WIDTH = 4;

	////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		OP_ADD = 5'd0,
		OP_SUB = 5'd1,
		OP_OR = 5'd3,
		OP_AND = 5'd4,
		OP_SHFT = 5'd5,
		OP_LOAD = 5'd10,
		OP_STOR = 5'd11,
		OP_INPUT = 5'd12,
		OP_OUTPUT = 5'd13,
		OP_NOP = 5'd15
	} opcode_t;

	typedef enum logic [2:0] {
		MODE_DIRECT = 3'd0,
		MODE_INDIRECT = 3'd1,
		MODE_IMMEDIATE = 3'd2
	} addrMode_t;

	// Same field, read as the variant of SHFT
	typedef enum logic [2:0] {
		SHIFT_LEFT_ZERO = 3'd0,
		SHIFT_LEFT_ONE = 3'd1,
		SHIFT_RIGHT_ZERO = 3'd2,
		SHIFT_RIGHT_ONE = 3'd3
	} shiftKind_t;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_AND
	} aluOp_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_ADDR,
		S_PTR_READ,
		S_MEM_READ,
		S_MEM_WRITE,
		S_EXECUTE,
		S_SHIFT,
		S_IN_WAIT,
		S_IN_TAKE,
		S_OUT_DRIVE,
		S_NOP_STEP
	} seqState_t;

endpackage

//--- source/stageSequencer.sv
`timescale 1ns/100ps

module stageSequencer (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input stageOnePkg::opcode_t opcode,
	input stageOnePkg::addrMode_t addrMode,
	input logic memDone,
	input logic inputReady,
	input logic outputTaken,
	output logic instrAccept,
	output logic instrLoad,
	output logic memActive,
	output stageOnePkg::seqState_t state
);
	import stageOnePkg::*;

	seqState_t nextState;
	seqState_t firstState;
	logic ptrFetched;  // Indirect pointer already read

	assign instrAccept = (state == S_IDLE);
	assign instrLoad = instrAccept && instrValid;
	assign memActive = (state == S_PTR_READ) || (state == S_MEM_READ) ||
		(state == S_MEM_WRITE);

	////////////////////////////////////////////////////////////
	// Entry state for a freshly accepted instruction
	////////////////////////////////////////////////////////////
	always_comb begin
		case (opcode)
			OP_ADD, OP_SUB, OP_OR, OP_AND, OP_LOAD: begin
				if (addrMode == MODE_IMMEDIATE)
					firstState = S_EXECUTE;
				else
					firstState = S_ADDR;
			end
			OP_STOR: firstState = S_ADDR;
			OP_SHFT: firstState = S_SHIFT;
			OP_INPUT: firstState = S_IN_WAIT;
			OP_OUTPUT: firstState = S_OUT_DRIVE;
			default: firstState = S_NOP_STEP;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Transitions
	////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		case (state)
			S_IDLE: begin
				if (instrLoad)
					nextState = firstState;
			end
			S_ADDR: begin
				if (addrMode == MODE_INDIRECT && !ptrFetched)
					nextState = S_PTR_READ;
				else if (opcode == OP_STOR)
					nextState = S_MEM_WRITE;
				else
					nextState = S_MEM_READ;
			end
			S_PTR_READ: begin
				if (memDone)
					nextState = S_ADDR;  // Second pass uses the pointer
			end
			S_MEM_READ: begin
				if (memDone)
					nextState = S_EXECUTE;
			end
			S_MEM_WRITE: begin
				if (memDone)
					nextState = S_IDLE;
			end
			S_IN_WAIT: begin
				if (inputReady)
					nextState = S_IN_TAKE;
			end
			S_OUT_DRIVE: begin
				if (outputTaken)
					nextState = S_IDLE;
			end
			S_EXECUTE, S_SHIFT, S_IN_TAKE, S_NOP_STEP: nextState = S_IDLE;
			default: nextState = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ptrFetched <= 1'b0;
		end else if (state == S_IDLE) begin
			ptrFetched <= 1'b0;
		end else if (state == S_PTR_READ && memDone) begin
			ptrFetched <= 1'b1;
		end
	end

endmodule

//--- tests/stageOneTb.sv
`timescale 1ns/100ps

module stageOneTb;
	import stageOnePkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_INSTR = 400;
	localparam int MAX_GAP = 3;  // Idle cycles before an instruction
	localparam int MAX_STALL = 6;  // Longest device wait
	localparam int CYCLES_PER_INSTR = 2 * (MISS_LIMIT + 1) + MAX_STALL + MAX_GAP + 10;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_INSTR * CYCLES_PER_INSTR) * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'd90924;

	typedef struct packed {
		int reads;
		int writes;
		int acc;
		aluOp_t op;
		int shift;
		logic left;
		logic fill;
		logic [SHIFT_AMOUNT_WIDTH-1:0] amount;
		int inXfer;
		int outXfer;
	} effect_t;

	logic clk;
	logic reset;
	logic [INSTR_WIDTH-1:0] instr;
	logic [DATA_WIDTH-1:0] irData;
	logic instrValid, cacheHit, inputReady, outputTaken;
	logic instrAccept, accWrite, memRead, memWrite;
	logic shiftEnable, shiftLeft, shiftFill, inputTaken, outputValid;
	logic [SHIFT_AMOUNT_WIDTH-1:0] shiftAmount;
	aluOp_t aluOp;

	int errorCount = 0;
	logic stimDone = 1'b0;
	logic allChecked = 1'b0;
	logic [4:0] opChoices[$];
	effect_t expected;
	effect_t seen;

	stageOneCtrl dut_i (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic effect_t expectedEffect(input logic [7:0] ins, input logic [7:0] data);
		effect_t e;
		logic [2:0] mode;
		e = '0;
		mode = ins[2:0];
		case (ins[7:3])
			OP_ADD, OP_SUB, OP_OR, OP_AND, OP_LOAD: begin
				if (mode <= 3'd2) begin
					e.reads = (mode == 3'd2) ? 0 : int'(mode) + 1;
					e.acc = 1;
					case (ins[7:3])
						OP_ADD: e.op = ALU_ADD;
						OP_SUB: e.op = ALU_SUB;
						OP_OR: e.op = ALU_OR;
						OP_AND: e.op = ALU_AND;
						default: e.op = ALU_PASS;
					endcase
				end
			end
			OP_STOR: begin
				if (mode <= 3'd1) begin
					e.reads = int'(mode);  // Pointer fetch only
					e.writes = 1;
				end
			end
			OP_SHFT: begin
				if (mode <= 3'd3) begin
					e.shift = 1;
					e.left = !mode[1];
					e.fill = mode[0];
					e.amount = data[SHIFT_AMOUNT_WIDTH-1:0];
				end
			end
			OP_INPUT: begin
				e.inXfer = 1;
				e.acc = 1;
			end
			OP_OUTPUT: e.outXfer = 1;
			default: ;
		endcase
		return e;
	endfunction

	task automatic compareValue(input string what, input int got, input int want);
		if (got != want) begin
			errorCount++;
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic checkEffect();
		compareValue("memRead accesses", seen.reads, expected.reads);
		compareValue("memWrite accesses", seen.writes, expected.writes);
		compareValue("accWrite pulses", seen.acc, expected.acc);
		if (expected.acc != 0)
			compareValue("aluOp at accWrite", int'(seen.op), int'(expected.op));
		compareValue("shiftEnable pulses", seen.shift, expected.shift);
		if (expected.shift != 0) begin
			compareValue("shiftLeft", int'(seen.left), int'(expected.left));
			compareValue("shiftFill", int'(seen.fill), int'(expected.fill));
			compareValue("shiftAmount", int'(seen.amount), int'(expected.amount));
		end
		compareValue("inputTaken pulses", seen.inXfer, expected.inXfer);
		compareValue("output transfers", seen.outXfer, expected.outXfer);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Cache and device models
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] devRng;
		logic [1:0] hitPhase;
		int readyWait;
		int takenWait;
		devRng = ~SEED;
		hitPhase = 2'd0;
		readyWait = 0;
		takenWait = 0;
		cacheHit = 1'b0;
		inputReady = 1'b0;
		outputTaken = 1'b0;
		forever begin
			@(negedge clk);
			devRng = xorshift(devRng);
			if (instrAccept)
				hitPhase = devRng[13:12];  // New cache behavior per instruction
			case (hitPhase)
				2'd0: cacheHit = devRng[0];
				2'd1: cacheHit = 1'b1;
				default: cacheHit = 1'b0;  // Runs into the miss limit
			endcase
			inputReady = (devRng[5:4] == 2'd0) || (readyWait == MAX_STALL);
			outputTaken = (devRng[9:8] == 2'd0) || (takenWait == MAX_STALL);
			readyWait = inputReady ? 0 : readyWait + 1;
			takenWait = outputTaken ? 0 : takenWait + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Monitor and comparison
	////////////////////////////////////////////////////////////
	initial begin
		logic memNow;
		logic inAccess;
		logic endDue;
		logic prevReady;
		logic prevOutValid;
		logic prevOutTaken;
		logic haveCurrent;
		logic resetChecked;
		int accessLen;
		inAccess = 1'b0;
		endDue = 1'b0;
		prevReady = 1'b0;
		prevOutValid = 1'b0;
		prevOutTaken = 1'b0;
		haveCurrent = 1'b0;
		resetChecked = 1'b0;
		accessLen = 0;
		forever begin
			@(posedge clk);
			if (!reset) begin
				if (!resetChecked) begin
					compareValue("instrAccept after reset", int'(instrAccept), 1);
					compareValue("strobes after reset", int'({accWrite, memRead, memWrite,
						shiftEnable, inputTaken, outputValid}), 0);
					resetChecked = 1'b1;
				end
				memNow = memRead || memWrite;
				if (inAccess)
					compareValue("memory strobe after access cycle", int'(memNow), int'(!endDue));
				if (memNow && (!inAccess || endDue)) begin
					accessLen = 0;
					seen.reads += int'(memRead);
					seen.writes += int'(memWrite);
				end
				if (memNow) begin
					accessLen++;
					endDue = cacheHit || (accessLen == MISS_LIMIT + 1);
				end
				inAccess = memNow;
				if (accWrite) begin
					seen.acc++;
					seen.op = aluOp;
				end
				if (shiftEnable) begin
					seen.shift++;
					seen.left = shiftLeft;
					seen.fill = shiftFill;
					seen.amount = shiftAmount;
				end
				if (inputTaken) begin
					seen.inXfer++;
					compareValue("inputReady before inputTaken", int'(prevReady), 1);
				end
				if (prevOutValid && !prevOutTaken)
					compareValue("outputValid held until taken", int'(outputValid), 1);
				if (outputValid && outputTaken)
					seen.outXfer++;
				prevReady = inputReady;
				prevOutValid = outputValid;
				prevOutTaken = outputTaken;
				if (instrAccept && haveCurrent) begin
					checkEffect();  // Back in IDLE, so the instruction is complete
					haveCurrent = 1'b0;
				end
				if (instrAccept && instrValid) begin
					expected = expectedEffect(instr, irData);
					seen = '0;
					haveCurrent = 1'b1;
				end
				if (stimDone && instrAccept && !haveCurrent)
					allChecked = 1'b1;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns with instructions still in flight", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] stimRng;
		logic [2:0] mode;
		stimRng = SEED;
		opChoices = '{5'd0, 5'd1, 5'd3, 5'd4, 5'd5, 5'd10, 5'd11, 5'd12, 5'd13, 5'd15,
			5'd2, 5'd9, 5'd23};  // Last three are unused codes
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		irData = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < NUM_INSTR; i++) begin
			stimRng = xorshift(stimRng);
			repeat (stimRng[25:24]) @(negedge clk);
			stimRng = xorshift(stimRng);
			mode = (stimRng[15:13] == 3'd0) ? stimRng[2:0] : {1'b0, stimRng[5:4]};
			instr = {opChoices[stimRng[31:16] % opChoices.size()], mode};
			irData = stimRng[12:5];
			instrValid = 1'b1;
			while (!instrAccept)
				@(negedge clk);
			@(negedge clk);  // Accept edge has passed
			instrValid = 1'b0;
		end
		stimDone = 1'b1;
		wait (allChecked);
		$display("Run finished with %0d instructions and %0d errors", NUM_INSTR, errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- tests/stageOne_properties.sv
`timescale 1ns/100ps

module stageOneProperties (
	input logic clk,
	input logic reset,
	input logic instrAccept,
	input logic accWrite,
	input logic memRead,
	input logic memWrite,
	input logic shiftEnable,
	input logic inputTaken,
	input logic outputValid
);
	import stageOnePkg::*;

	logic anyStrobe;
	logic [4:0] memRun;  // Cycles of the current access so far

	assign anyStrobe = accWrite || memRead || memWrite || shiftEnable || inputTaken ||
		outputValid;

	always_ff @(posedge clk) begin
		if (reset || !(memRead || memWrite))
			memRun <= '0;
		else if (memRun != '1)
			memRun <= memRun + 1'b1;
	end

	memExclusive: assert property (@(posedge clk) disable iff (reset)
		!(memRead && memWrite))
		else $error("memRead and memWrite asserted together");

	accSingle: assert property (@(posedge clk) disable iff (reset)
		accWrite |=> !accWrite)
		else $error("accWrite held longer than one cycle");

	acceptQuiet: assert property (@(posedge clk) disable iff (reset)
		instrAccept |-> !anyStrobe)
		else $error("instrAccept high while a strobe is active");

	accessBound: assert property (@(posedge clk) disable iff (reset)
		(memRead || memWrite) |-> (memRun < 5'(MISS_LIMIT + 1)))
		else $error("memory access longer than %0d cycles", MISS_LIMIT + 1);

endmodule

bind stageOneCtrl stageOneProperties stageOneProperties_i (
	.clk(clk),
	.reset(reset),
	.instrAccept(instrAccept),
	.accWrite(accWrite),
	.memRead(memRead),
	.memWrite(memWrite),
	.shiftEnable(shiftEnable),
	.inputTaken(inputTaken),
	.outputValid(outputValid)
);

//--- verilog.f
source/stageOnePkg.sv
source/instrDecoder.sv
source/memWaitTimer.sv
source/stageSequencer.sv
source/controlDecode.sv
source/stageOneCtrl.sv
tests/stageOne_properties.sv
tests/stageOneTb.sv
